//--- verilog/csr_pkg.sv
package csr_pkg;

    // ####################################################################
    // csr addresses
    // ####################################################################

    typedef enum logic [11:0] {
        csr_mvendorid  = 12'hf11,
        csr_marchid    = 12'hf12,
        csr_mimpid     = 12'hf13,
        csr_mhartid    = 12'hf14,
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mcounteren = 12'h306,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344
    } csr_addr_e;

    // ####################################################################
    // bus and core side structs
    // ####################################################################

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } csr_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        interrupt;
        logic [4:0]  code;
        logic [31:0] epc;
        logic [31:0] tval;
    } trap_req_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

    // ####################################################################
    // field positions, masks and fixed values
    // ####################################################################

    localparam int mstatus_mie_pos  = 3;
    localparam int mstatus_mpie_pos = 7;

    // same positions in mie and mip.
    localparam int irq_msip_pos = 3;
    localparam int irq_mtip_pos = 7;
    localparam int irq_meip_pos = 11;

    localparam logic [31:0] mie_wmask        = 32'h0000_0888;
    // mode bit 1 is hardwired, so only direct and vectored remain.
    localparam logic [31:0] mtvec_wmask      = 32'hffff_fffd;
    localparam logic [31:0] mcounteren_wmask = 32'h0000_0007;
    localparam logic [31:0] mcause_wmask     = 32'h8000_001f;
    localparam logic [31:0] mepc_wmask       = 32'hffff_fffc;

    // rv32i plus m.
    localparam logic [31:0] misa_value    = 32'h4000_1100;
    localparam logic [31:0] mstatus_reset = 32'h0000_1800;

endpackage

//--- verilog/csr_apb_port.sv
`timescale 1ns/1ps

module csr_apb_port (
    input  logic               clk,
    input  logic               rst_n,

    // apb slave side.
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [11:0]        paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,

    // internal side.
    output csr_pkg::csr_req_t  req,
    input  csr_pkg::csr_rsp_t  rsp
);

    logic setup_phase;
    logic access_q;

    // setup cycle is the only one that raises a request.
    assign setup_phase = psel & ~penable;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            access_q <= 1'b0;
        end else begin
            access_q <= setup_phase;
        end
    end

    // no wait states.
    assign pready = access_q;

    always_comb begin
        req.valid = setup_phase;
        req.write = pwrite;
        req.addr  = paddr;
        req.wdata = pwdata;
    end

    // response was registered by the csr block at the end of setup.
    assign prdata  = rsp.rdata;
    assign pslverr = access_q & rsp.err;

endmodule

//--- verilog/mstatus_reg.sv
`timescale 1ns/1ps

module mstatus_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [31:0]         wdata,
    input  csr_pkg::trap_req_t  trap_req,
    input  logic                mret,
    output logic [31:0]         mstatus,
    output logic                mie_bit
);

    import csr_pkg::*;

    logic mie_q;
    logic mpie_q;

    // trap first, then mret, then a bus write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= mstatus_reset[mstatus_mie_pos];
            mpie_q <= mstatus_reset[mstatus_mpie_pos];
        end else if (trap_req.valid) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr_en) begin
            mie_q  <= wdata[mstatus_mie_pos];
            mpie_q <= wdata[mstatus_mpie_pos];
        end
    end

    // only machine mode exists, MPP stays 3 from the reset value.
    always_comb begin
        mstatus                   = mstatus_reset;
        mstatus[mstatus_mie_pos]  = mie_q;
        mstatus[mstatus_mpie_pos] = mpie_q;
    end

    assign mie_bit = mie_q;

endmodule

//--- verilog/m_trap_setup_regs.sv
`timescale 1ns/1ps

module m_trap_setup_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  req,
    input  logic               wr_en,
    output logic [31:0]        mie,
    output logic [31:0]        mtvec,
    output logic [31:0]        mcounteren
);

    import csr_pkg::*;

    // ####################################################################
    // mie
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie <= 32'b0;
        end else if (wr_en && req.addr == csr_mie) begin
            mie <= req.wdata & mie_wmask;
        end
    end

    // ####################################################################
    // mtvec
    // ####################################################################

    // base in 31:2, mode in 0.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= 32'b0;
        end else if (wr_en && req.addr == csr_mtvec) begin
            mtvec <= req.wdata & mtvec_wmask;
        end
    end

    // ####################################################################
    // mcounteren
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcounteren <= 32'b0;
        end else if (wr_en && req.addr == csr_mcounteren) begin
            mcounteren <= req.wdata & mcounteren_wmask;
        end
    end

endmodule

//--- verilog/m_trap_handling_regs.sv
`timescale 1ns/1ps

module m_trap_handling_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_req_t   req,
    input  logic                wr_en,
    input  csr_pkg::trap_req_t  trap_req,
    input  csr_pkg::irq_lines_t irq_lines,
    output logic [31:0]         mscratch,
    output logic [31:0]         mepc,
    output logic [31:0]         mcause,
    output logic [31:0]         mtval,
    output logic [31:0]         mip
);

    import csr_pkg::*;

    logic [31:0] mip_next;

    // scratch is untouched by traps.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= 32'b0;
        end else if (wr_en && req.addr == csr_mscratch) begin
            mscratch <= req.wdata;
        end
    end

    // ####################################################################
    // trap state, a trap beats a bus write
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= 32'b0;
            mcause <= 32'b0;
            mtval  <= 32'b0;
        end else if (trap_req.valid) begin
            // instructions are word aligned.
            mepc   <= trap_req.epc & mepc_wmask;
            mcause <= {trap_req.interrupt, 26'b0, trap_req.code};
            mtval  <= trap_req.tval;
        end else if (wr_en) begin
            case (req.addr)
                csr_mepc:   mepc   <= req.wdata & mepc_wmask;
                csr_mcause: mcause <= req.wdata & mcause_wmask;
                csr_mtval:  mtval  <= req.wdata;
                default: begin
                end
            endcase
        end
    end

    // ####################################################################
    // pending interrupts
    // ####################################################################

    always_comb begin
        mip_next               = 32'b0;
        mip_next[irq_msip_pos] = irq_lines.msip;
        mip_next[irq_mtip_pos] = irq_lines.mtip;
        mip_next[irq_meip_pos] = irq_lines.meip;
    end

    // sampled every cycle, bus writes never reach it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= 32'b0;
        end else begin
            mip <= mip_next;
        end
    end

endmodule

//--- verilog/csrs.sv
`timescale 1ns/1ps

module csrs #(
    parameter logic [31:0] mvendorid_value = 32'h0,
    parameter logic [31:0] marchid_value   = 32'h0,
    parameter logic [31:0] mimpid_value    = 32'h0,
    parameter logic [31:0] mhartid_value   = 32'h0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  csr_pkg::trap_req_t  trap_req,
    input  logic                mret,
    input  csr_pkg::irq_lines_t irq_lines,
    output logic [31:0]         trap_target,
    output logic [31:0]         mepc_out,
    output logic                irq_pending
);

    import csr_pkg::*;

    csr_req_t    req;
    csr_req_t    wr_q;
    csr_rsp_t    rsp_q;
    logic        implemented;
    logic        read_only;
    logic        access_err;
    logic [31:0] rd_value;
    logic        mstatus_wr;
    logic        setup_wr;
    logic        handling_wr;
    logic        mstatus_mie;
    logic [31:0] mtvec_base;
    logic [31:0] mstatus, mie, mtvec, mcounteren;
    logic [31:0] mscratch, mepc, mcause, mtval, mip;

    csr_apb_port i_csr_apb_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .rsp     (rsp_q)
    );

    // ####################################################################
    // decode and read mux
    // ####################################################################

    always_comb begin
        implemented = 1'b1;
        read_only   = 1'b0;
        rd_value    = 32'b0;
        case (req.addr)
            csr_mvendorid:  begin rd_value = mvendorid_value; read_only = 1'b1; end
            csr_marchid:    begin rd_value = marchid_value;   read_only = 1'b1; end
            csr_mimpid:     begin rd_value = mimpid_value;    read_only = 1'b1; end
            csr_mhartid:    begin rd_value = mhartid_value;   read_only = 1'b1; end
            csr_misa:       begin rd_value = misa_value;      read_only = 1'b1; end
            csr_mip:        begin rd_value = mip;             read_only = 1'b1; end
            csr_mstatus:    rd_value = mstatus;
            csr_mie:        rd_value = mie;
            csr_mtvec:      rd_value = mtvec;
            csr_mcounteren: rd_value = mcounteren;
            csr_mscratch:   rd_value = mscratch;
            csr_mepc:       rd_value = mepc;
            csr_mcause:     rd_value = mcause;
            csr_mtval:      rd_value = mtval;
            default:        implemented = 1'b0;
        endcase
    end

    assign access_err = ~implemented | (req.write & read_only);

    // response at the end of setup, legal write held for the access cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q <= '0;
            wr_q  <= '0;
        end else begin
            wr_q.valid <= req.valid & req.write & ~access_err;
            if (req.valid) begin
                rsp_q.rdata <= rd_value;
                rsp_q.err   <= access_err;
                wr_q.write  <= req.write;
                wr_q.addr   <= req.addr;
                wr_q.wdata  <= req.wdata;
            end
        end
    end

    assign mstatus_wr  = wr_q.valid && wr_q.addr == csr_mstatus;
    assign setup_wr    = wr_q.valid && wr_q.addr inside {csr_mie, csr_mtvec, csr_mcounteren};
    assign handling_wr = wr_q.valid &&
                         wr_q.addr inside {csr_mscratch, csr_mepc, csr_mcause, csr_mtval};

    // ####################################################################
    // register blocks
    // ####################################################################

    mstatus_reg i_mstatus_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (mstatus_wr),
        .wdata    (wr_q.wdata),
        .trap_req (trap_req),
        .mret     (mret),
        .mstatus  (mstatus),
        .mie_bit  (mstatus_mie)
    );

    m_trap_setup_regs i_m_trap_setup_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (wr_q),
        .wr_en      (setup_wr),
        .mie        (mie),
        .mtvec      (mtvec),
        .mcounteren (mcounteren)
    );

    m_trap_handling_regs i_m_trap_handling_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (wr_q),
        .wr_en     (handling_wr),
        .trap_req  (trap_req),
        .irq_lines (irq_lines),
        .mscratch  (mscratch),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .mip       (mip)
    );

    // ####################################################################
    // core side outputs
    // ####################################################################

    assign mtvec_base = {mtvec[31:2], 2'b00};

    // vectored mode only applies to interrupts.
    assign trap_target = (mtvec[0] && trap_req.interrupt) ?
                         mtvec_base + {25'b0, trap_req.code, 2'b00} : mtvec_base;

    assign mepc_out    = mepc;
    assign irq_pending = mstatus_mie & (|(mie & mip));

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release lands on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tests/csrs_tb.sv
`timescale 1ns/1ps

module csrs_tb;

    import csr_pkg::*;

    localparam int clk_period_ns = 20;

    localparam logic [31:0] vendor_id = 32'h0000_0a5e;
    localparam logic [31:0] arch_id   = 32'h0000_0017;
    localparam logic [31:0] impl_id   = 32'h0003_0c01;
    localparam logic [31:0] hart_id   = 32'h0000_0002;

    localparam logic [31:0] mask_mie        = 32'h0000_0888;
    localparam logic [31:0] mask_mtvec      = 32'hffff_fffd;
    localparam logic [31:0] mask_mcounteren = 32'h0000_0007;
    localparam logic [31:0] mask_mcause     = 32'h8000_001f;
    localparam logic [31:0] mask_mepc       = 32'hffff_fffc;
    localparam logic [31:0] isa_word        = 32'h4000_1100;
    localparam logic [31:0] mstatus_fixed   = 32'h0000_1800;

    // transfers per test.
    localparam int rand_rounds    = 4;
    localparam int reset_xfers    = 14;
    localparam int rand_xfers     = rand_rounds * 8 * 2 + 4;
    localparam int error_xfers    = 6 + 4 * 2 + 14;
    localparam int trap_xfers     = 4 * 6;
    localparam int mret_xfers     = 4;
    localparam int irq_xfers      = 2 * 8 * 2 + 2 * 8;
    localparam int total_xfers    = reset_xfers + rand_xfers + error_xfers + trap_xfers +
                                    mret_xfers + irq_xfers;
    localparam int timeout_cycles = total_xfers * 4 + 300;

    localparam logic [13:0][11:0] all_addrs = {
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_mstatus, csr_misa, csr_mie,
        csr_mtvec, csr_mcounteren, csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip
    };
    localparam logic [7:0][11:0] writable_addrs = {
        csr_mstatus, csr_mie, csr_mtvec, csr_mcounteren,
        csr_mscratch, csr_mepc, csr_mcause, csr_mtval
    };
    localparam logic [5:0][11:0] read_only_addrs = {
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_misa, csr_mip
    };
    localparam logic [3:0][11:0] unimpl_addrs = {12'h000, 12'h302, 12'h345, 12'hfff};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    trap_req_t   trap_req;
    logic        mret;
    irq_lines_t  irq_lines;
    logic [31:0] trap_target;
    logic [31:0] mepc_out;
    logic        irq_pending;

    // register model.
    logic        exp_mie_bit;
    logic        exp_mpie_bit;
    logic [31:0] exp_mie;
    logic [31:0] exp_mtvec;
    logic [31:0] exp_mcounteren;
    logic [31:0] exp_mscratch;
    logic [31:0] exp_mepc;
    logic [31:0] exp_mcause;
    logic [31:0] exp_mtval;
    logic [2:0]  exp_lines;
    logic [31:0] lfsr_state;

    tb_clock #(
        .period_ns    (clk_period_ns),
        .reset_cycles (4)
    ) i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csrs #(
        .mvendorid_value (vendor_id),
        .marchid_value   (arch_id),
        .mimpid_value    (impl_id),
        .mhartid_value   (hart_id)
    ) i_csrs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .trap_req    (trap_req),
        .mret        (mret),
        .irq_lines   (irq_lines),
        .trap_target (trap_target),
        .mepc_out    (mepc_out),
        .irq_pending (irq_pending)
    );

    // ####################################################################
    // random source and reference functions
    // ####################################################################

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'ha300_0000;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = 32'b0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // msip to bit 3, mtip to bit 7, meip to bit 11.
    function automatic logic [31:0] spread_irq(input logic [2:0] v);
        return {20'b0, v[2], 3'b0, v[1], 3'b0, v[0], 3'b0};
    endfunction

    function automatic csr_rsp_t expect_rsp(input logic [11:0] addr, input logic write);
        csr_rsp_t rsp;
        logic     ro;
        rsp = '0;
        ro  = addr inside {csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_misa,
                           csr_mip};
        case (addr)
            csr_mvendorid:  rsp.rdata = vendor_id;
            csr_marchid:    rsp.rdata = arch_id;
            csr_mimpid:     rsp.rdata = impl_id;
            csr_mhartid:    rsp.rdata = hart_id;
            csr_misa:       rsp.rdata = isa_word;
            csr_mip:        rsp.rdata = spread_irq(exp_lines);
            csr_mstatus:    rsp.rdata = mstatus_fixed |
                                        {24'b0, exp_mpie_bit, 3'b0, exp_mie_bit, 3'b0};
            csr_mie:        rsp.rdata = exp_mie;
            csr_mtvec:      rsp.rdata = exp_mtvec;
            csr_mcounteren: rsp.rdata = exp_mcounteren;
            csr_mscratch:   rsp.rdata = exp_mscratch;
            csr_mepc:       rsp.rdata = exp_mepc;
            csr_mcause:     rsp.rdata = exp_mcause;
            csr_mtval:      rsp.rdata = exp_mtval;
            default:        rsp.err   = 1'b1;
        endcase
        rsp.err = rsp.err | (write & ro);
        return rsp;
    endfunction

    function automatic logic [31:0] expect_target(input logic [31:0] tvec,
                                                  input logic interrupt,
                                                  input logic [4:0] code);
        logic [31:0] base;
        base = {tvec[31:2], 2'b00};
        if (tvec[1:0] == 2'b01 && interrupt) begin
            return base + 32'(code) * 32'd4;
        end
        return base;
    endfunction

    function automatic logic expect_pending(input logic mie_bit, input logic [31:0] mie_word,
                                            input logic [2:0] lines);
        return mie_bit & (|(mie_word & spread_irq(lines)));
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
        case (addr)
            csr_mstatus: begin
                exp_mie_bit  = data[3];
                exp_mpie_bit = data[7];
            end
            csr_mie:        exp_mie        = data & mask_mie;
            csr_mtvec:      exp_mtvec      = data & mask_mtvec;
            csr_mcounteren: exp_mcounteren = data & mask_mcounteren;
            csr_mscratch:   exp_mscratch   = data;
            csr_mepc:       exp_mepc       = data & mask_mepc;
            csr_mcause:     exp_mcause     = data & mask_mcause;
            csr_mtval:      exp_mtval      = data;
            default: begin
            end
        endcase
    endtask

    // ####################################################################
    // compare tasks
    // ####################################################################

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rsp(input string name, input csr_rsp_t got, input csr_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got rdata %h err %h, expected rdata %h err %h",
                     name, got.rdata, got.err, exp.rdata, exp.err);
            stop_run();
        end
    endtask

    // ####################################################################
    // bus and core drivers
    // ####################################################################

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!pready && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            $display("APB transfer got no pready within 8 cycles");
            stop_run();
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] data, output csr_rsp_t rsp);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        wait_ready();
        rsp.rdata = prdata;
        rsp.err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_and_check(input logic [11:0] addr, input logic [31:0] data);
        csr_rsp_t exp;
        csr_rsp_t got;
        exp = expect_rsp(addr, 1'b1);
        apb_transfer(1'b1, addr, data, got);
        check_bit($sformatf("pslverr on write to %h", addr), got.err, exp.err);
        if (!exp.err) begin
            model_write(addr, data);
        end
    endtask

    task automatic read_and_check(input logic [11:0] addr);
        csr_rsp_t exp;
        csr_rsp_t got;
        exp = expect_rsp(addr, 1'b0);
        apb_transfer(1'b0, addr, 32'b0, got);
        check_rsp($sformatf("prdata,pslverr at %h", addr), got, exp);
    endtask

    task automatic run_trap(input logic interrupt);
        logic [31:0] epc;
        logic [31:0] tval;
        logic [31:0] code;
        random_bits(32, epc);
        random_bits(32, tval);
        random_bits(5, code);
        trap_req.valid     = 1'b1;
        trap_req.interrupt = interrupt;
        trap_req.code      = code[4:0];
        trap_req.epc       = epc;
        trap_req.tval      = tval;
        #(clk_period_ns / 4);
        check_word("trap_target", trap_target, expect_target(exp_mtvec, interrupt, code[4:0]));
        @(negedge clk);
        trap_req.valid = 1'b0;
        exp_mepc       = epc & mask_mepc;
        exp_mcause     = {interrupt, 26'b0, code[4:0]};
        exp_mtval      = tval;
        exp_mpie_bit   = exp_mie_bit;
        exp_mie_bit    = 1'b0;
        check_word("mepc_out", mepc_out, exp_mepc);
        read_and_check(csr_mepc);
        read_and_check(csr_mcause);
        read_and_check(csr_mtval);
        read_and_check(csr_mstatus);
    endtask

    task automatic run_mret(input logic [31:0] status);
        write_and_check(csr_mstatus, status);
        mret = 1'b1;
        @(negedge clk);
        mret         = 1'b0;
        exp_mie_bit  = exp_mpie_bit;
        exp_mpie_bit = 1'b1;
        read_and_check(csr_mstatus);
        check_word("mepc_out", mepc_out, exp_mepc);
    endtask

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        #(timeout_cycles * clk_period_ns);
        $display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
        stop_run();
    end

    initial begin
        logic [31:0] word;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = 12'b0;
        pwdata         = 32'b0;
        trap_req       = '0;
        mret           = 1'b0;
        irq_lines      = '0;
        exp_mie_bit    = 1'b0;
        exp_mpie_bit   = 1'b0;
        exp_mie        = 32'b0;
        exp_mtvec      = 32'b0;
        exp_mcounteren = 32'b0;
        exp_mscratch   = 32'b0;
        exp_mepc       = 32'b0;
        exp_mcause     = 32'b0;
        exp_mtval      = 32'b0;
        exp_lines      = 3'b0;
        lfsr_state     = 32'd44;

        wait (rst_n);
        @(negedge clk);
        check_bit("pready", pready, 1'b0);
        check_bit("pslverr", pslverr, 1'b0);
        check_bit("irq_pending", irq_pending, 1'b0);

        // reset values.
        for (int i = 0; i < 14; i++) begin
            read_and_check(all_addrs[i]);
        end

        // masked writes, then mtvec modes 2 and 3.
        for (int r = 0; r < rand_rounds; r++) begin
            for (int i = 0; i < 8; i++) begin
                random_bits(32, word);
                write_and_check(writable_addrs[i], word);
                read_and_check(writable_addrs[i]);
            end
        end
        for (int mode = 2; mode < 4; mode++) begin
            random_bits(30, word);
            write_and_check(csr_mtvec, {word[29:0], mode[1:0]});
            read_and_check(csr_mtvec);
        end

        // read-only and unimplemented addresses.
        for (int i = 0; i < 6; i++) begin
            random_bits(32, word);
            write_and_check(read_only_addrs[i], word);
        end
        for (int i = 0; i < 4; i++) begin
            random_bits(32, word);
            write_and_check(unimpl_addrs[i], word);
            read_and_check(unimpl_addrs[i]);
        end
        for (int i = 0; i < 14; i++) begin
            read_and_check(all_addrs[i]);
        end

        // traps in direct and vectored mode.
        for (int mode = 0; mode < 2; mode++) begin
            for (int intr = 0; intr < 2; intr++) begin
                random_bits(32, word);
                write_and_check(csr_mtvec, {word[31:2], 1'b0, mode[0]});
                random_bits(32, word);
                // mpie starts opposite to mie.
                word[3] = mode[0] ^ intr[0];
                word[7] = ~word[3];
                write_and_check(csr_mstatus, word);
                run_trap(intr[0]);
            end
        end

        run_mret(32'h0000_0080);
        run_mret(32'h0000_0008);

        // pending flag over MIE, mie and the lines.
        for (int m = 0; m < 2; m++) begin
            for (int e = 0; e < 8; e++) begin
                write_and_check(csr_mstatus, m[0] ? 32'h8 : 32'h0);
                random_bits(32, word);
                write_and_check(csr_mie, (word & ~mask_mie) | spread_irq(e[2:0]));
                for (int l = 0; l < 8; l++) begin
                    irq_lines = irq_lines_t'(l[2:0]);
                    check_bit("irq_pending", irq_pending,
                              expect_pending(exp_mie_bit, exp_mie, exp_lines));
                    @(negedge clk);
                    exp_lines = l[2:0];
                    check_bit("irq_pending", irq_pending,
                              expect_pending(exp_mie_bit, exp_mie, exp_lines));
                    if (e == 7) begin
                        read_and_check(csr_mip);
                    end
                end
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sim.f
verilog/csr_pkg.sv
verilog/csr_apb_port.sv
verilog/mstatus_reg.sv
verilog/m_trap_setup_regs.sv
verilog/m_trap_handling_regs.sv
verilog/csrs.sv
tests/tb_clock.sv
tests/csrs_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module csrs_tb
./obj_dir/Vcsrs_tb
